/* compile.f */
sys_pkg.sv
mem_bank.sv
mem_arbiter.sv
io_regs.sv
axil_cpu_port.sv
system_top.sv
tb_system.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the system testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_system \
	-o sim_tb_system > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb_system > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	echo "Simulation log has no pass line"
	exit 1
fi
exit 0

/* tb_system.sv */
`default_nettype none

module tb_system;
	import sys_pkg::*;

	localparam int TICKS = 50;
	localparam int TIMEOUT = 300;

	logic clk_24;
	logic rst_n;
	addr_t awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	addr_t araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [14:0] dn_addr;
	logic dn_wr;
	logic [7:0] dn_data;
	logic [7:0] dn_index;
	logic [31:0] joystick;
	logic [32:0] timestamp;
	logic pause;
	logic hold;

	logic [31:0] lcg_state;
	int errors;
	int k;
	logic [31:0] r;
	logic [7:0] got;
	logic [15:0] tval;
	logic [63:0] ts_wide;
	// Reference copies of the program ROM and the work RAM
	logic [7:0] rom_model [0:32767];
	logic [7:0] ram_model [0:16383];
	logic [15:0] ram_addrs [0:31];

	system_top #(
		.TICKS_PER_MS(TICKS)
	) dut0 (.*);

	initial
	begin
		clk_24 = 1'b0;
		forever #10 clk_24 = ~clk_24;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stop_run();
		errors++;
		$display("RESULT: FAIL");
		$fatal(1, "testbench check failed");
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		$display("Fail %s expected 0x%0h actual 0x%0h", name, exp, act);
		stop_run();
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		stop_run();
	endtask

	task automatic expect_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp)
		else
			report_mismatch(name, {8'd0, exp}, {8'd0, act});
	endtask

	// One AXI write, bready held low for stall cycles once bvalid is up
	task automatic write_axi(input addr_t a, input logic [7:0] d, input logic [3:0] strb,
		input int stall);
		int n;
		@(posedge clk_24);
		#2;
		awaddr = a;
		wdata = {24'h5aa53c, d};
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		@(negedge clk_24);
		while (!(awready && wready))
		begin
			n++;
			if (n > TIMEOUT)
				report_problem("Timeout waiting for awready and wready");
			@(negedge clk_24);
		end
		@(posedge clk_24);
		#2;
		awvalid = 1'b0;
		wvalid = 1'b0;
		n = 0;
		@(negedge clk_24);
		while (!bvalid)
		begin
			n++;
			if (n > TIMEOUT)
				report_problem("Timeout waiting for bvalid");
			@(negedge clk_24);
		end
		assert (bresp == 2'b00)
		else
			report_problem("Write response was not OKAY");
		repeat (stall + 1) @(posedge clk_24);
		#2;
		bready = 1'b1;
		@(posedge clk_24);
		#2;
		bready = 1'b0;
	endtask

	// One AXI read, rready held low for stall cycles once rvalid is up
	task automatic read_axi(input addr_t a, input int stall, output logic [7:0] d);
		int n;
		@(posedge clk_24);
		#2;
		araddr = a;
		arvalid = 1'b1;
		n = 0;
		@(negedge clk_24);
		while (!arready)
		begin
			n++;
			if (n > TIMEOUT)
				report_problem("Timeout waiting for arready");
			@(negedge clk_24);
		end
		@(posedge clk_24);
		#2;
		arvalid = 1'b0;
		n = 0;
		@(negedge clk_24);
		while (!rvalid)
		begin
			n++;
			if (n > TIMEOUT)
				report_problem("Timeout waiting for rvalid");
			@(negedge clk_24);
		end
		d = rdata[7:0];
		assert (rdata[31:8] == 24'd0 && rresp == 2'b00)
		else
			report_problem("Read response had upper data bits set or was not OKAY");
		repeat (stall + 1) @(posedge clk_24);
		#2;
		rready = 1'b1;
		@(posedge clk_24);
		#2;
		rready = 1'b0;
	endtask

	// Back to back download writes, one per cycle
	task automatic download_bytes(input logic [14:0] start, input int count,
		input logic [7:0] idx);
		int i;
		logic [31:0] v;
		for (i = 0; i < count; i++)
		begin
			@(posedge clk_24);
			#2;
			v = next_rand();
			dn_addr = start + 15'(i);
			dn_data = v[15:8];
			dn_index = idx;
			dn_wr = 1'b1;
			if (idx == 8'd0)
				rom_model[dn_addr] = dn_data;
		end
		@(posedge clk_24);
		#2;
		dn_wr = 1'b0;
	endtask

	r_resp_stable: assert property (@(posedge clk_24) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
	else
		report_problem("Read response changed while rready was low");

	b_resp_stable: assert property (@(posedge clk_24) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
	else
		report_problem("Write response dropped while bready was low");

	hold_blocks: assert property (@(posedge clk_24) disable iff (!rst_n)
		hold |-> !arready && !awready && !wready)
	else
		report_problem("Port offered a handshake while hold was high");

	initial
	begin
		lcg_state = 32'h2de2_f7cb;
		errors = 0;
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		dn_addr = '0;
		dn_wr = 1'b0;
		dn_data = '0;
		dn_index = '0;
		pause = 1'b0;
		joystick = next_rand();
		timestamp = {1'b1, next_rand()};
		repeat (4) @(posedge clk_24);
		#2;
		rst_n = 1'b1;
		@(negedge clk_24);
		assert (!bvalid && !rvalid && !awready && !wready && !arready && !hold)
		else
			report_problem("Outputs were not idle after reset");

		// ROM load, then writes and foreign downloads that must not stick
		download_bytes(15'h0000, 64, 8'd0);
		for (k = 0; k < 64; k++)
		begin
			read_axi(16'(k), 0, got);
			expect_byte($sformatf("rom_load %04h", k), rom_model[15'(k)], got);
		end
		download_bytes(15'h0000, 8, 8'd1);
		write_axi(16'h0003, 8'h77, 4'h1, 0);
		write_axi(16'h0005, 8'h66, 4'he, 0);
		for (k = 0; k < 8; k++)
		begin
			read_axi(16'(k), 0, got);
			expect_byte($sformatf("rom_protect %04h", k), rom_model[15'(k)], got);
		end

		// Work RAM with back-pressure on both response channels
		for (k = 0; k < 32; k++)
		begin
			r = next_rand();
			ram_addrs[5'(k)] = {2'b11, r[13:0]};
			ram_model[r[13:0]] = r[23:16];
			write_axi({2'b11, r[13:0]}, r[23:16], 4'h1, k % 3);
		end
		write_axi(ram_addrs[0], 8'hee, 4'h0, 0);
		for (k = 0; k < 32; k++)
		begin
			read_axi(ram_addrs[5'(k)], (k % 4) * 2, got);
			expect_byte($sformatf("work_ram %04h", ram_addrs[5'(k)]),
				ram_model[ram_addrs[5'(k)][13:0]], got);
		end

		// Mapped inputs and an unmapped page
		ts_wide = {31'd0, timestamp};
		for (k = 0; k < 4; k++)
		begin
			read_axi(16'h8100 + 16'(k), 0, got);
			expect_byte($sformatf("joystick %0d", k), joystick[5'(8 * k) +: 8], got);
		end
		for (k = 0; k < 8; k++)
		begin
			read_axi(16'h8800 + 16'(k), 0, got);
			expect_byte($sformatf("timestamp %0d", k), ts_wide[6'(8 * k) +: 8], got);
		end
		read_axi(16'h9000, 0, got);
		expect_byte("unmapped 9000", 8'h00, got);

		// Timer, three milliseconds after a clear
		write_axi(16'h8900, 8'h00, 4'h1, 0);
		repeat (3 * TICKS) @(posedge clk_24);
		read_axi(16'h8900, 0, got);
		tval[7:0] = got;
		read_axi(16'h8901, 0, got);
		tval[15:8] = got;
		assert (tval == 16'd3 || tval == 16'd2)
		else
			report_mismatch("timer", 16'd3, tval);

		// Pause trigger stalls a read until the pause input clears it
		write_axi(16'h8a30, 8'h01, 4'h1, 0);
		@(negedge clk_24);
		assert (hold)
		else
			report_problem("hold did not rise after the pause trigger write");
		fork
			read_axi(ram_addrs[1], 0, got);
			begin
				repeat (8)
				begin
					@(negedge clk_24);
					assert (arvalid && !arready)
					else
						report_problem("Read was accepted while hold was high");
				end
				@(posedge clk_24);
				#2;
				pause = 1'b1;
				@(posedge clk_24);
				#2;
				pause = 1'b0;
			end
		join
		expect_byte("pause_read", ram_model[ram_addrs[1][13:0]], got);
		assert (!hold)
		else
			report_problem("hold stayed high after the pause pulse");

		// Download burst racing CPU reads of the work RAM
		fork
			download_bytes(15'h0100, 48, 8'd0);
			begin
				for (k = 0; k < 12; k++)
				begin
					read_axi(ram_addrs[5'(k)], 0, got);
					expect_byte($sformatf("arb_ram %04h", ram_addrs[5'(k)]),
						ram_model[ram_addrs[5'(k)][13:0]], got);
				end
			end
		join
		for (k = 0; k < 48; k++)
		begin
			read_axi(16'h0100 + 16'(k), 0, got);
			expect_byte($sformatf("arb_rom %04h", 16'h0100 + 16'(k)),
				rom_model[15'h0100 + 15'(k)], got);
		end

		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* system_top.sv */
`default_nettype none

module system_top #(
	parameter int unsigned TICKS_PER_MS = 24000
) (
	input logic clk_24,
	input logic rst_n,

	// CPU side, AXI4-Lite
	input sys_pkg::addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input logic [sys_pkg::AXI_DW-1:0] wdata,
	input logic [sys_pkg::AXI_DW/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input sys_pkg::addr_t araddr,
	input logic arvalid,
	output logic arready,
	output logic [sys_pkg::AXI_DW-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,

	// ROM download port
	input logic [sys_pkg::PGROM_AW-1:0] dn_addr,
	input logic dn_wr,
	input logic [7:0] dn_data,
	input logic [7:0] dn_index,

	input logic [31:0] joystick,
	input logic [32:0] timestamp,
	input logic pause,
	output logic hold
);
	import sys_pkg::*;

	bus_req_t mem_req;
	bus_rsp_t mem_rsp;
	bus_req_t io_req;
	bus_rsp_t io_rsp;
	dn_req_t dn_req;

	// Only the program ROM index is downloadable
	assign dn_req.valid = dn_wr && dn_index == DN_INDEX_PGROM;
	assign dn_req.addr = dn_addr;
	assign dn_req.data = dn_data;

	axil_cpu_port axil_cpu_port0 (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.hold(hold),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.io_req(io_req),
		.io_rsp(io_rsp)
	);

	mem_arbiter mem_arbiter0 (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.cpu_req(mem_req),
		.cpu_rsp(mem_rsp),
		.dn_req(dn_req)
	);

	io_regs #(
		.TICKS_PER_MS(TICKS_PER_MS)
	) io_regs0 (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.req(io_req),
		.rsp(io_rsp),
		.joystick(joystick),
		.timestamp(timestamp),
		.pause(pause),
		.hold(hold)
	);

endmodule

`default_nettype wire

/* axil_cpu_port.sv */
`default_nettype none

module axil_cpu_port (
	input logic clk_24,
	input logic rst_n,
	input sys_pkg::addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input logic [sys_pkg::AXI_DW-1:0] wdata,
	input logic [sys_pkg::AXI_DW/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input sys_pkg::addr_t araddr,
	input logic arvalid,
	output logic arready,
	output logic [sys_pkg::AXI_DW-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic hold,
	output sys_pkg::bus_req_t mem_req,
	input sys_pkg::bus_rsp_t mem_rsp,
	output sys_pkg::bus_req_t io_req,
	input sys_pkg::bus_rsp_t io_rsp
);
	import sys_pkg::*;

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ISSUE = 2'd1;
	localparam logic [1:0] ST_RESP = 2'd2;
	localparam logic [1:0] RESP_OKAY = 2'b00;

	logic [1:0] state;
	logic rd_take;
	logic wr_take;
	cpu_addr_u acc_addr;
	bus_req_t req_q;
	logic to_io;
	bus_rsp_t tgt_rsp;
	byte_t rdata_q;

	// Reads win when both channels are offered
	assign arready = state == ST_IDLE && !hold && arvalid;
	assign rd_take = arready && arvalid;
	assign awready = state == ST_IDLE && !hold && awvalid && wvalid && !arvalid;
	assign wready = awready;
	assign wr_take = awready;

	assign acc_addr = rd_take ? araddr : awaddr;
	assign tgt_rsp = to_io ? io_rsp : mem_rsp;

	always_comb
	begin
		mem_req = req_q;
		mem_req.valid = req_q.valid && !to_io;
		io_req = req_q;
		io_req.valid = req_q.valid && to_io;
	end

	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			req_q <= '0;
			to_io <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					to_io <= acc_addr.mem_view.region == REGION_IO;
					if (rd_take)
					begin
						req_q <= '{valid: 1'b1, write: 1'b0, addr: araddr, wdata: 8'd0};
						state <= ST_ISSUE;
					end
					else if (wr_take && wstrb[0])
					begin
						req_q <= '{valid: 1'b1, write: 1'b1, addr: awaddr, wdata: wdata[7:0]};
						state <= ST_ISSUE;
					end
					else if (wr_take)
					begin
						// No byte enabled, nothing to store
						bvalid <= 1'b1;
						state <= ST_RESP;
					end
				end
				ST_ISSUE:
				begin
					if (tgt_rsp.valid)
					begin
						req_q.valid <= 1'b0;
						bvalid <= req_q.write;
						rvalid <= !req_q.write;
						state <= ST_RESP;
					end
				end
				default:
				begin
					if ((bvalid && bready) || (rvalid && rready))
					begin
						bvalid <= 1'b0;
						rvalid <= 1'b0;
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_24)
	begin
		if (state == ST_ISSUE && tgt_rsp.valid && !req_q.write)
		begin
			rdata_q <= tgt_rsp.rdata;
		end
	end

	assign rdata = {{(AXI_DW - 8){1'b0}}, rdata_q};
	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

	a_r_stable: assert property (@(posedge clk_24) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata));

	a_b_stable: assert property (@(posedge clk_24) disable iff (!rst_n)
		bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

/* io_regs.sv */
`default_nettype none

module io_regs #(
	parameter int unsigned TICKS_PER_MS = 24000
) (
	input logic clk_24,
	input logic rst_n,
	input sys_pkg::bus_req_t req,
	output sys_pkg::bus_rsp_t rsp,
	input logic [31:0] joystick,
	input logic [32:0] timestamp,
	input logic pause,
	output logic hold
);
	import sys_pkg::*;

	localparam int unsigned PRE_W = $clog2(TICKS_PER_MS + 1);

	cpu_addr_u ia;
	logic take;
	logic wr_take;
	logic timer_cs;
	logic pause_cs;
	logic [PRE_W-1:0] prescale;
	logic [15:0] timer;
	logic [63:0] ts_wide;
	logic pause_trigger;
	byte_t rd_byte;

	assign ia = req.addr;
	// Act once per request, in the cycle before the response
	assign take = req.valid && !rsp.valid;
	assign wr_take = take && req.write;
	assign timer_cs = ia.io_view.page == PAGE_TIMER;
	assign pause_cs = ia.io_view.page == PAGE_SYSCTL && ia.io_view.offset[7:4] == PAUSE_OFS_HI;
	assign ts_wide = {31'd0, timestamp};

	// Millisecond timer, cleared with its prescaler by any write to its page
	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prescale <= '0;
			timer <= '0;
		end
		else if (wr_take && timer_cs)
		begin
			prescale <= '0;
			timer <= '0;
		end
		else if (prescale == PRE_W'(TICKS_PER_MS - 1))
		begin
			prescale <= '0;
			timer <= timer + 16'd1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

	// Pause input wins over a trigger write in the same cycle
	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pause_trigger <= 1'b0;
		end
		else if (pause)
		begin
			pause_trigger <= 1'b0;
		end
		else if (wr_take && pause_cs)
		begin
			pause_trigger <= 1'b1;
		end
	end

	assign hold = pause || pause_trigger;

	always_comb
	begin
		case (ia.io_view.page)
			PAGE_JOYSTICK: rd_byte = joystick[{ia.io_view.offset[1:0], 3'd0} +: 8];
			PAGE_TIMESTAMP: rd_byte = ts_wide[{ia.io_view.offset[2:0], 3'd0} +: 8];
			PAGE_TIMER: rd_byte = timer[{ia.io_view.offset[0], 3'd0} +: 8];
			default: rd_byte = '0;
		endcase
	end

	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rsp <= '0;
		end
		else
		begin
			rsp.valid <= take;
			rsp.rdata <= req.write ? 8'd0 : rd_byte;
		end
	end

	a_rsp_needs_req: assert property (@(posedge clk_24) disable iff (!rst_n)
		$rose(rsp.valid) |-> $past(req.valid));

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`default_nettype none

module mem_arbiter (
	input logic clk_24,
	input logic rst_n,
	input sys_pkg::bus_req_t cpu_req,
	output sys_pkg::bus_rsp_t cpu_rsp,
	input sys_pkg::dn_req_t dn_req
);
	import sys_pkg::*;

	cpu_addr_u ca;
	logic cpu_is_ram;
	logic cpu_go;
	logic pend;
	logic bank_sel_ram;
	logic bank_we;
	logic [PGROM_AW-1:0] bank_addr;
	byte_t bank_wdata;
	byte_t bank_rdata;

	assign ca = cpu_req.addr;
	assign cpu_is_ram = ca.mem_view.region == REGION_WKRAM;

	// CPU waits for any download write and for its own outstanding access
	assign cpu_go = cpu_req.valid && !dn_req.valid && !pend && !cpu_rsp.valid;

	always_comb
	begin
		if (dn_req.valid)
		begin
			// Download always lands in the program ROM
			bank_sel_ram = 1'b0;
			bank_we = 1'b1;
			bank_addr = dn_req.addr;
			bank_wdata = dn_req.data;
		end
		else
		begin
			bank_sel_ram = cpu_is_ram;
			// ROM is read only from the CPU side
			bank_we = cpu_go && cpu_req.write && cpu_is_ram;
			bank_addr = {ca.mem_view.region[0], ca.mem_view.offset};
			bank_wdata = cpu_req.wdata;
		end
	end

	mem_bank mem_bank0 (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.sel_ram(bank_sel_ram),
		.we(bank_we),
		.addr(bank_addr),
		.wdata(bank_wdata),
		.rdata(bank_rdata)
	);

	// Grant, then bank read, then response
	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pend <= 1'b0;
			cpu_rsp <= '0;
		end
		else
		begin
			pend <= cpu_go;
			cpu_rsp.valid <= pend;
			cpu_rsp.rdata <= bank_rdata;
		end
	end

	// A CPU response comes from a grant that had the bank to itself
	a_cpu_not_during_dn: assert property (@(posedge clk_24) disable iff (!rst_n)
		$rose(cpu_rsp.valid) |-> $past(!dn_req.valid, 2));

endmodule

`default_nettype wire

/* mem_bank.sv */
`default_nettype none

module mem_bank (
	input logic clk_24,
	input logic rst_n,
	input logic sel_ram,
	input logic we,
	input logic [sys_pkg::PGROM_AW-1:0] addr,
	input sys_pkg::byte_t wdata,
	output sys_pkg::byte_t rdata
);
	import sys_pkg::*;

	// Program ROM, 0x0000 to 0x7FFF
	byte_t pgrom [0:(1 << PGROM_AW)-1];
	// Work RAM, 0xC000 to 0xFFFF
	byte_t wkram [0:(1 << WKRAM_AW)-1];

	logic [WKRAM_AW-1:0] ram_addr;

	assign ram_addr = addr[WKRAM_AW-1:0];

	always_ff @(posedge clk_24)
	begin
		if (we && sel_ram)
		begin
			wkram[ram_addr] <= wdata;
		end
		if (we && !sel_ram)
		begin
			pgrom[addr] <= wdata;
		end
	end

	// Registered read, data valid one cycle after the access
	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rdata <= '0;
		end
		else
		begin
			rdata <= sel_ram ? wkram[ram_addr] : pgrom[addr];
		end
	end

endmodule

`default_nettype wire

/* sys_pkg.sv */
`default_nettype none

package sys_pkg;

	// Basic CPU bus types
	typedef logic [15:0] addr_t;
	typedef logic [7:0] byte_t;

	// One CPU address, seen either as a memory region or as an I/O page
	typedef union packed {
		struct packed {
			logic [7:0] page;
			logic [7:0] offset;
		} io_view;
		struct packed {
			logic [1:0] region;
			logic [13:0] offset;
		} mem_view;
	} cpu_addr_u;

	// Request from the AXI port to a target
	typedef struct packed {
		logic valid;
		logic write;
		addr_t addr;
		byte_t wdata;
	} bus_req_t;

	// Target response, one per request
	typedef struct packed {
		logic valid;
		byte_t rdata;
	} bus_rsp_t;

	// Program ROM download write
	typedef struct packed {
		logic valid;
		logic [14:0] addr;
		byte_t data;
	} dn_req_t;

	// Memory map, upper two address bits
	// Regions 00 and 01 together are the program ROM
	localparam logic [1:0] REGION_IO = 2'b10;
	localparam logic [1:0] REGION_WKRAM = 2'b11;

	// I/O pages
	localparam byte_t PAGE_JOYSTICK = 8'h81;
	localparam byte_t PAGE_TIMESTAMP = 8'h88;
	localparam byte_t PAGE_TIMER = 8'h89;
	localparam byte_t PAGE_SYSCTL = 8'h8A;
	// Pause trigger sits at offsets 0x30 to 0x3F of the system page
	localparam logic [3:0] PAUSE_OFS_HI = 4'h3;

	// Memory geometry
	localparam int PGROM_AW = 15;
	localparam int WKRAM_AW = 14;

	localparam byte_t DN_INDEX_PGROM = 8'd0;

	localparam int AXI_DW = 32;

endpackage

`default_nettype wire
